// ==== cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ********************
// datapath widths
// ********************

// data word and instruction word
`define CPU_DATA_W   16

// general register file
`define CPU_REG_NUM  8
`define CPU_REG_AW   3

// immediate field in bits 7..0
`define CPU_IMM_W    8

// fetch address
`define CPU_PC_W     16

`endif

// ==== cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

    // ********************
    // basic types
    // ********************

    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    // ********************
    // instruction format
    // ********************
    // [15:11] major opcode
    // [10:8]  rx
    // [7:5]   ry
    // [4:2]   rz, register-register ops only
    // [7:0]   immediate, ADDIU and LI

    // codes 7 to 31 are not named and behave like OP_NOP
    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_ADDU  = 5'd1,
        OP_SUBU  = 5'd2,
        OP_AND   = 5'd3,
        OP_OR    = 5'd4,
        OP_ADDIU = 5'd5,
        OP_LI    = 5'd6
    } opcode_e;

    // pass_b hands operand b through, used by LI
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_PASS_B = 3'd4
    } alu_op_e;

endpackage

// ==== issue_if.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

interface issue_if;
    import cpu_pkg::*;

    // issue register contents, decode to execute
    logic      valid;
    alu_op_e   alu_op;
    reg_addr_t dest;
    reg_addr_t src_a_addr;
    reg_addr_t src_b_addr;
    data_t     a_data;
    data_t     b_data;
    data_t     imm;
    logic      use_imm;

    // driven from the issue register
    modport decode (
        output valid, alu_op, dest,
        output src_a_addr, src_b_addr,
        output a_data, b_data, imm, use_imm
    );

    // read by forwarding and the alu
    modport execute (
        input valid, alu_op, dest,
        input src_a_addr, src_b_addr,
        input a_data, b_data, imm, use_imm
    );

endinterface

// ==== fetch_decode.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_decode (
    input  logic                  clk_50MHz,
    input  logic                  rst,
    input  cpu_pkg::data_t        inst_i,
    output logic [`CPU_PC_W-1:0]  pc_o,
    output cpu_pkg::reg_addr_t    rd_addr_a_o,
    output cpu_pkg::reg_addr_t    rd_addr_b_o,
    input  cpu_pkg::data_t        rd_data_a_i,
    input  cpu_pkg::data_t        rd_data_b_i,
    issue_if.decode               issue
);
    import cpu_pkg::*;

    logic [`CPU_PC_W-1:0]  pc_q;
    data_t                 if_inst_q;
    logic                  if_valid_q;

    opcode_e               opcode;
    reg_addr_t             rx;
    reg_addr_t             ry;
    reg_addr_t             rz;
    logic [`CPU_IMM_W-1:0] imm8;

    logic                  dec_writes;
    alu_op_e               dec_alu_op;
    reg_addr_t             dec_dest;
    logic                  dec_use_imm;
    data_t                 dec_imm;

    // ********************
    // fetch
    // ********************

    // no stalls, so pc just counts
    always_ff @(posedge clk_50MHz or negedge rst)
    begin
        if (!rst)
        begin
            pc_q       <= '0;
            if_inst_q  <= '0;
            if_valid_q <= 1'b0;
        end
        else
        begin
            pc_q       <= pc_q + 1'b1;
            if_inst_q  <= inst_i;
            if_valid_q <= 1'b1;
        end
    end

    assign pc_o = pc_q;

    // ********************
    // decode
    // ********************

    assign opcode = opcode_e'(if_inst_q[15:11]);
    assign rx     = if_inst_q[10:8];
    assign ry     = if_inst_q[7:5];
    assign rz     = if_inst_q[4:2];
    assign imm8   = if_inst_q[`CPU_IMM_W-1:0];

    // register file read ports, always rx and ry
    assign rd_addr_a_o = rx;
    assign rd_addr_b_o = ry;

    always_comb
    begin
        dec_writes  = 1'b1;
        dec_alu_op  = ALU_ADD;
        dec_dest    = rz;
        dec_use_imm = 1'b0;
        // sign extension by default, LI overrides
        dec_imm     = {{(`CPU_DATA_W-`CPU_IMM_W){imm8[`CPU_IMM_W-1]}}, imm8};
        case (opcode)
            OP_ADDU:  dec_alu_op = ALU_ADD;
            OP_SUBU:  dec_alu_op = ALU_SUB;
            OP_AND:   dec_alu_op = ALU_AND;
            OP_OR:    dec_alu_op = ALU_OR;
            OP_ADDIU:
            begin
                dec_alu_op  = ALU_ADD;
                dec_dest    = rx;
                dec_use_imm = 1'b1;
            end
            OP_LI:
            begin
                dec_alu_op  = ALU_PASS_B;
                dec_dest    = rx;
                dec_use_imm = 1'b1;
                dec_imm     = {{(`CPU_DATA_W-`CPU_IMM_W){1'b0}}, imm8};
            end
            // nop and unknown codes
            default:  dec_writes = 1'b0;
        endcase
    end

    // ********************
    // issue register
    // ********************

    always_ff @(posedge clk_50MHz or negedge rst)
    begin
        if (!rst)
        begin
            issue.valid      <= 1'b0;
            issue.alu_op     <= ALU_ADD;
            issue.dest       <= '0;
            issue.src_a_addr <= '0;
            issue.src_b_addr <= '0;
            issue.a_data     <= '0;
            issue.b_data     <= '0;
            issue.imm        <= '0;
            issue.use_imm    <= 1'b0;
        end
        else
        begin
            issue.valid      <= if_valid_q & dec_writes;
            issue.alu_op     <= dec_alu_op;
            issue.dest       <= dec_dest;
            issue.src_a_addr <= rx;
            issue.src_b_addr <= ry;
            issue.a_data     <= rd_data_a_i;
            issue.b_data     <= rd_data_b_i;
            issue.imm        <= dec_imm;
            issue.use_imm    <= dec_use_imm;
        end
    end

endmodule

// ==== alu_execute.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu_execute (
    issue_if.execute              issue,
    input  logic                  wb_valid_i,
    input  cpu_pkg::reg_addr_t    wb_addr_i,
    input  cpu_pkg::data_t        wb_data_i,
    output logic                  res_valid_o,
    output cpu_pkg::reg_addr_t    res_addr_o,
    output cpu_pkg::data_t        res_data_o
);
    import cpu_pkg::*;

    logic  fwd_a;
    logic  fwd_b;
    data_t reg_a;
    data_t reg_b;
    data_t op_a;
    data_t op_b;
    data_t alu_y;

    // ********************
    // forwarding
    // ********************

    // the previous instruction sits in the result register right now;
    // older ones were already caught by the register file write-through
    assign fwd_a = wb_valid_i && (wb_addr_i == issue.src_a_addr);
    assign fwd_b = wb_valid_i && (wb_addr_i == issue.src_b_addr);

    assign reg_a = fwd_a ? wb_data_i : issue.a_data;
    assign reg_b = fwd_b ? wb_data_i : issue.b_data;

    // ********************
    // operand select
    // ********************

    assign op_a = reg_a;

    // immediate already extended in decode
    assign op_b = issue.use_imm ? issue.imm : reg_b;

    // ********************
    // alu
    // ********************

    // 16 bit wrap-around, carry and borrow dropped
    always_comb
    begin
        case (issue.alu_op)
            ALU_ADD:    alu_y = op_a + op_b;
            ALU_SUB:    alu_y = op_a - op_b;
            ALU_AND:    alu_y = op_a & op_b;
            ALU_OR:     alu_y = op_a | op_b;
            ALU_PASS_B: alu_y = op_b;
            default:    alu_y = '0;
        endcase
    end

    // result towards the result register
    assign res_valid_o = issue.valid;
    assign res_addr_o  = issue.dest;
    assign res_data_o  = alu_y;

endmodule

// ==== result_stage.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module result_stage (
    input  logic                  clk_50MHz,
    input  logic                  rst,
    input  logic                  res_valid_i,
    input  cpu_pkg::reg_addr_t    res_addr_i,
    input  cpu_pkg::data_t        res_data_i,
    input  cpu_pkg::reg_addr_t    rd_addr_a_i,
    input  cpu_pkg::reg_addr_t    rd_addr_b_i,
    output cpu_pkg::data_t        rd_data_a_o,
    output cpu_pkg::data_t        rd_data_b_o,
    output logic                  wb_valid_o,
    output cpu_pkg::reg_addr_t    wb_addr_o,
    output cpu_pkg::data_t        wb_data_o
);
    import cpu_pkg::*;

    logic      wb_valid_q;
    reg_addr_t wb_addr_q;
    data_t     wb_data_q;
    data_t     regs [`CPU_REG_NUM];

    // ********************
    // result register
    // ********************

    always_ff @(posedge clk_50MHz or negedge rst)
    begin
        if (!rst)
        begin
            wb_valid_q <= 1'b0;
            wb_addr_q  <= '0;
            wb_data_q  <= '0;
        end
        else
        begin
            wb_valid_q <= res_valid_i;
            wb_addr_q  <= res_addr_i;
            wb_data_q  <= res_data_i;
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_addr_o  = wb_addr_q;
    assign wb_data_o  = wb_data_q;

    // ********************
    // register file
    // ********************

    // written at the end of the write-back cycle
    always_ff @(posedge clk_50MHz or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < `CPU_REG_NUM; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_valid_q)
        begin
            regs[wb_addr_q] <= wb_data_q;
        end
    end

    // read with write-through of the pending write
    always_comb
    begin
        rd_data_a_o = regs[rd_addr_a_i];
        rd_data_b_o = regs[rd_addr_b_i];
        if (wb_valid_q && (wb_addr_q == rd_addr_a_i))
        begin
            rd_data_a_o = wb_data_q;
        end
        if (wb_valid_q && (wb_addr_q == rd_addr_b_i))
        begin
            rd_data_b_o = wb_data_q;
        end
    end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core (
    input  logic                  clk_50MHz,
    input  logic                  rst,
    input  cpu_pkg::data_t        inst_i,
    output logic [`CPU_PC_W-1:0]  pc_o,
    output logic                  wb_valid_o,
    output cpu_pkg::reg_addr_t    wb_addr_o,
    output cpu_pkg::data_t        wb_data_o
);
    import cpu_pkg::*;

    // register file read path
    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    data_t     rd_data_a;
    data_t     rd_data_b;

    // execute result into the result register
    logic      res_valid;
    reg_addr_t res_addr;
    data_t     res_data;

    issue_if issue ();

    // ********************
    // pipeline stages
    // ********************

    fetch_decode u_fetch_decode (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .inst_i      (inst_i),
        .pc_o        (pc_o),
        .rd_addr_a_o (rd_addr_a),
        .rd_addr_b_o (rd_addr_b),
        .rd_data_a_i (rd_data_a),
        .rd_data_b_i (rd_data_b),
        .issue       (issue.decode)
    );

    // write-back also feeds forwarding
    alu_execute u_alu_execute (
        .issue       (issue.execute),
        .wb_valid_i  (wb_valid_o),
        .wb_addr_i   (wb_addr_o),
        .wb_data_i   (wb_data_o),
        .res_valid_o (res_valid),
        .res_addr_o  (res_addr),
        .res_data_o  (res_data)
    );

    result_stage u_result_stage (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .res_valid_i (res_valid),
        .res_addr_i  (res_addr),
        .res_data_i  (res_data),
        .rd_addr_a_i (rd_addr_a),
        .rd_addr_b_i (rd_addr_b),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b),
        .wb_valid_o  (wb_valid_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

// ==== tb_cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int PROG_WORDS     = 64;
    localparam int DRIVE_DLY      = 2;
    localparam int LATENCY        = 3;
    localparam int TIMEOUT_CYCLES = 200;

    logic                 clk_50MHz;
    logic                 rst;
    data_t                inst_i;
    logic [`CPU_PC_W-1:0] pc_o;
    logic                 wb_valid_o;
    reg_addr_t            wb_addr_o;
    data_t                wb_data_o;

    data_t     prog [PROG_WORDS];
    int        exp_pc [$];
    reg_addr_t exp_addr [$];
    data_t     exp_data [$];
    int        exp_count;
    int        cycle;
    int        wr_idx;
    int        err_value;
    int        err_other;

    cpu_core uut (
        .clk_50MHz  (clk_50MHz),
        .rst        (rst),
        .inst_i     (inst_i),
        .pc_o       (pc_o),
        .wb_valid_o (wb_valid_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    // ********************
    // program and model
    // ********************

    function automatic data_t rr_word(input logic [4:0] op, input int rx, input int ry,
                                      input int rz);
        return {op, 3'(rx), 3'(ry), 3'(rz), 2'b00};
    endfunction

    function automatic data_t imm_word(input logic [4:0] op, input int rx,
                                       input logic [7:0] imm);
        return {op, 3'(rx), imm};
    endfunction

    // past the end of the program the memory returns nop
    function automatic data_t word_at(input logic [`CPU_PC_W-1:0] pc);
        data_t w;
        w = '0;
        if (pc < PROG_WORDS)
        begin
            w = prog[pc];
        end
        return w;
    endfunction

    // in-order ISA model, fills the expected write lists
    function automatic int build_expected();
        data_t      rf [`CPU_REG_NUM];
        data_t      word;
        logic [7:0] imm;
        reg_addr_t  rx;
        reg_addr_t  dst;
        data_t      res;
        logic       wr;
        for (int r = 0; r < `CPU_REG_NUM; r++)
        begin
            rf[r] = '0;
        end
        for (int pc = 0; pc < PROG_WORDS; pc++)
        begin
            word = prog[pc];
            rx   = word[10:8];
            imm  = word[7:0];
            dst  = word[4:2];
            wr   = 1'b1;
            res  = '0;
            case (word[15:11])
                OP_ADDU:  res = rf[rx] + rf[word[7:5]];
                OP_SUBU:  res = rf[rx] - rf[word[7:5]];
                OP_AND:   res = rf[rx] & rf[word[7:5]];
                OP_OR:    res = rf[rx] | rf[word[7:5]];
                OP_ADDIU:
                begin
                    res = rf[rx] + {{8{imm[7]}}, imm};
                    dst = rx;
                end
                OP_LI:
                begin
                    res = {8'h00, imm};
                    dst = rx;
                end
                default:  wr = 1'b0;
            endcase
            if (wr)
            begin
                rf[dst] = res;
                exp_pc.push_back(pc);
                exp_addr.push_back(dst);
                exp_data.push_back(res);
            end
        end
        return exp_pc.size();
    endfunction

    task automatic load_program();
        logic [4:0] op;
        // immediates, zero extend and sign extend with wrap
        prog[0]  = imm_word(OP_LI, 1, 8'hff);
        prog[1]  = imm_word(OP_LI, 2, 8'h05);
        prog[2]  = imm_word(OP_ADDIU, 2, 8'h7f);
        prog[3]  = imm_word(OP_ADDIU, 1, 8'h80);
        prog[4]  = imm_word(OP_LI, 3, 8'h00);
        prog[5]  = imm_word(OP_ADDIU, 3, 8'h80);
        // register ops and forwarding chains
        prog[6]  = rr_word(OP_ADDU, 1, 2, 4);
        prog[7]  = rr_word(OP_SUBU, 1, 2, 5);
        prog[8]  = rr_word(OP_AND, 5, 4, 6);
        prog[9]  = rr_word(OP_OR, 3, 6, 7);
        prog[10] = rr_word(OP_ADDU, 7, 7, 0);
        prog[11] = '0;
        prog[12] = {5'd9, 11'h5a5};
        prog[13] = rr_word(OP_SUBU, 0, 7, 1);
        prog[14] = {5'd31, 11'h7ff};
        prog[15] = imm_word(OP_ADDIU, 1, 8'h01);
        prog[16] = rr_word(OP_AND, 6, 1, 2);
        // random tail, about one in nine is an unknown code
        for (int pc = 17; pc < PROG_WORDS; pc++)
        begin
            op = 5'($urandom_range(0, 8));
            if (op == 5'd8)
            begin
                op = 5'($urandom_range(7, 31));
            end
            prog[pc] = {op, 11'($urandom)};
        end
    endtask

    // ********************
    // stimulus
    // ********************

    always @(posedge clk_50MHz)
    begin
        #DRIVE_DLY inst_i = word_at(pc_o);
    end

    initial
    begin
        int waited;
        int drain;
        clk_50MHz = 1'b0;
        rst       = 1'b0;
        inst_i    = '0;
        cycle     = 0;
        wr_idx    = 0;
        err_value = 0;
        err_other = 0;
        waited    = 0;
        drain     = 0;
        void'($urandom(32'haf99_4d0a));
        load_program();
        exp_count = build_expected();
        repeat (4) @(posedge clk_50MHz);
        #DRIVE_DLY rst = 1'b1;
        while ((wr_idx < exp_count) && (waited < TIMEOUT_CYCLES))
        begin
            @(posedge clk_50MHz);
            waited++;
        end
        assert (wr_idx == exp_count)
        else
        begin
            err_other++;
            $display("the expected writes did not all arrive, got %0d of %0d",
                     wr_idx, exp_count);
        end
        // trailing cycles catch stray writes
        while (drain < 8)
        begin
            @(posedge clk_50MHz);
            drain++;
        end
        $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
        if ((err_value == 0) && (err_other == 0))
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // ********************
    // comparison
    // ********************

    always @(negedge clk_50MHz)
    begin
        if (!rst)
        begin
            assert (wb_valid_o === 1'b0)
            else
            begin
                err_value++;
                $display("error %0t: wb_valid_o high during reset", $time);
            end
        end
        else
        begin
            assert (pc_o === cycle[`CPU_PC_W-1:0])
            else
            begin
                err_value++;
                $display("error %0t: pc_o %0h, expected %0h", $time, pc_o, cycle);
            end
            if (cycle < LATENCY)
            begin
                assert (wb_valid_o === 1'b0)
                else
                begin
                    err_value++;
                    $display("error %0t: write in cycle %0d after reset", $time, cycle);
                end
            end
            if (wb_valid_o === 1'b1)
            begin
                assert (wr_idx < exp_count)
                else
                begin
                    err_value++;
                    $display("error %0t: unexpected write r%0d = %h", $time, wb_addr_o,
                             wb_data_o);
                end
                if (wr_idx < exp_count)
                begin
                    assert (cycle == exp_pc[wr_idx] + LATENCY)
                    else
                    begin
                        err_value++;
                        $display("error %0t: write of pc %0d in cycle %0d", $time,
                                 exp_pc[wr_idx], cycle);
                    end
                    assert ((wb_addr_o === exp_addr[wr_idx]) &&
                            (wb_data_o === exp_data[wr_idx]))
                    else
                    begin
                        err_value++;
                        $display("error %0t: pc %0d wrote r%0d = %h, expected r%0d = %h",
                                 $time, exp_pc[wr_idx], wb_addr_o, wb_data_o,
                                 exp_addr[wr_idx], exp_data[wr_idx]);
                    end
                    wr_idx++;
                end
            end
            cycle++;
        end
    end

endmodule

// ==== tb.f ====
+incdir+.
cpu_pkg.sv
issue_if.sv
fetch_decode.sv
alu_execute.sv
result_stage.sv
cpu_core.sv
tb_cpu_core.sv

// ==== Bender.yml ====
package:
  name: cpu_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - issue_if.sv
      - fetch_decode.sv
      - alu_execute.sv
      - result_stage.sv
      - cpu_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu_core.sv
